/* bench/mmu_tb_ops.svh */
`ifndef MMU_TB_OPS_SVH
`define MMU_TB_OPS_SVH

task automatic await_ack(string name);
    int waited;
    waited = 0;
    do begin
        @(posedge aclk);
        #drive_delay;
        waited++;
    end while (!wb_rsp.ack);
    check_value({name, " ack cycles"}, 32'd1, waited);
endtask

// ack drops for one cycle before the slave takes the next request
task automatic release_bus();
    wb_req = '0;
    @(posedge aclk);
    #drive_delay;
endtask

task automatic write_reg(string name, logic [reg_adr_w-1:0] adr, logic [31:0] dat);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
    await_ack(name);
    release_bus();
endtask

task automatic read_reg(string name, logic [reg_adr_w-1:0] adr, logic [31:0] exp);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'h0};
    await_ack(name);
    check_value(name, exp, wb_rsp.dat);
    release_bus();
endtask

task automatic translate(string name, bit on_data, logic [31:0] vaddr, bit store,
                         logic [31:0] exp_pa, logic [1:0] exp_exc);
    int        waited;
    xlat_rsp_t got;
    waited = 0;
    if (on_data) begin
        data_req = '{valid: 1'b1, vaddr: vaddr, store: store};
    end else begin
        ifetch_req = '{valid: 1'b1, vaddr: vaddr, store: store};
    end
    do begin
        @(posedge aclk);
        #drive_delay;
        waited++;
        got = on_data ? data_rsp : ifetch_rsp;
    end while (!got.valid);
    data_req   = '0;
    ifetch_req = '0;
    check_value({name, " latency"}, 32'd1, waited);
    check_value({name, " exc"}, {30'b0, exp_exc}, {30'b0, got.exc});
    check_value({name, " paddr"}, exp_pa, got.paddr);
endtask

`endif

/* bench/mmu_tb.sv */
`default_nettype none

module mmu_tb
    import mmu_pkg::*;
();

    localparam int drive_delay = 10;
    localparam int op_wr       = 0;
    localparam int op_rd       = 1;
    localparam int op_fetch    = 2;
    localparam int op_data     = 3;

    typedef struct {
        string       name;
        int          op;
        logic [31:0] addr;
        bit          store;
        logic [31:0] wdata;
        logic [31:0] exp;
        logic [1:0]  exc;
    } row_t;

    logic      aclk;
    logic      arst_n;
    wb_req_t   wb_req;
    wb_rsp_t   wb_rsp;
    xlat_req_t ifetch_req;
    xlat_rsp_t ifetch_rsp;
    xlat_req_t data_req;
    xlat_rsp_t data_rsp;

    row_t rows[$];
    int   cycles = 0;
    int   limit = 40;

    mmu_top dut_i (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .ifetch_req (ifetch_req),
        .ifetch_rsp (ifetch_rsp),
        .data_req   (data_req),
        .data_rsp   (data_rsp)
    );

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        assert (act === exp) else begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            $display("RESULT: FAIL");
            $fatal(1, "check failed");
        end
    endtask

    `include "mmu_tb_ops.svh"

    function automatic void add_row(string name, int op, logic [31:0] addr, bit store,
                                    logic [31:0] wdata, logic [31:0] exp, logic [1:0] exc);
        row_t r;
        r = '{name, op, addr, store, wdata, exp, exc};
        rows.push_back(r);
    endfunction

    // translation rows hold the frame base, the offset is added when applied
    function automatic void load_table();
        add_row("k0_fetch", op_fetch, 32'h8000_1000, 0, 0, 32'h0000_1000, exc_none);
        add_row("k1_data_st", op_data, 32'hA012_3000, 1, 0, 32'h0012_3000, exc_none);
        add_row("empty_refill", op_fetch, 32'h0040_0000, 0, 0, 0, exc_refill);
        add_row("hi_wr", op_wr, reg_entryhi, 0, 32'hFFFF_FFFF, 0, exc_none);
        add_row("hi_rd", op_rd, reg_entryhi, 0, 0, 32'hFFFF_E0FF, exc_none);
        add_row("lo0_wr", op_wr, reg_entrylo0, 0, 32'hFFFF_FFFF, 0, exc_none);
        add_row("lo0_rd", op_rd, reg_entrylo0, 0, 0, 32'h03FF_FFFF, exc_none);
        add_row("lo1_wr", op_wr, reg_entrylo1, 0, 32'h1234_5678, 0, exc_none);
        add_row("lo1_rd", op_rd, reg_entrylo1, 0, 0, 32'h0234_5678, exc_none);
        add_row("idx_wr", op_wr, reg_index, 0, 32'hFFFF_FFFF, 0, exc_none);
        add_row("idx_rd", op_rd, reg_index, 0, 0, 32'h8000_000F, exc_none);
        add_row("cmd_rd", op_rd, reg_cmd, 0, 0, 32'h0, exc_none);
        // entry 2, asid 5, even page dirty, odd page clean
        add_row("a_hi", op_wr, reg_entryhi, 0, 32'h0040_0005, 0, exc_none);
        add_row("a_lo0", op_wr, reg_entrylo0, 0, 32'h0048_D15E, 0, exc_none);
        add_row("a_lo1", op_wr, reg_entrylo1, 0, 32'h002A_F352, 0, exc_none);
        add_row("a_idx", op_wr, reg_index, 0, 32'h2, 0, exc_none);
        add_row("a_tlbwi", op_wr, reg_cmd, 0, cmd_tlbwi, 0, exc_none);
        // entry 5, global, even page invalid
        add_row("b_hi", op_wr, reg_entryhi, 0, 32'h1000_0007, 0, exc_none);
        add_row("b_lo0", op_wr, reg_entrylo0, 0, 32'h0001_DDC5, 0, exc_none);
        add_row("b_lo1", op_wr, reg_entrylo1, 0, 32'h0002_2207, 0, exc_none);
        add_row("b_idx", op_wr, reg_index, 0, 32'h5, 0, exc_none);
        add_row("b_tlbwi", op_wr, reg_cmd, 0, cmd_tlbwi, 0, exc_none);
        add_row("asid5", op_wr, reg_entryhi, 0, 32'h0040_0005, 0, exc_none);
        add_row("a_even_f", op_fetch, 32'h0040_0000, 0, 0, 32'h1234_5000, exc_none);
        add_row("a_odd_ld", op_data, 32'h0040_1000, 0, 0, 32'h0ABC_D000, exc_none);
        add_row("a_odd_st", op_data, 32'h0040_1000, 1, 0, 0, exc_modify);
        add_row("a_odd_f_st", op_fetch, 32'h0040_1000, 1, 0, 32'h0ABC_D000, exc_none);
        add_row("b_even_inv", op_fetch, 32'h1000_0000, 0, 0, 0, exc_invalid);
        add_row("b_odd_st", op_data, 32'h1000_1000, 1, 0, 32'h0088_8000, exc_none);
        add_row("nomap_data", op_data, 32'h0060_0000, 0, 0, 0, exc_refill);
        add_row("asid9", op_wr, reg_entryhi, 0, 32'h0040_0009, 0, exc_none);
        add_row("a_other_asid", op_fetch, 32'h0040_0000, 0, 0, 0, exc_refill);
        add_row("b_global", op_data, 32'h1000_1000, 0, 0, 32'h0088_8000, exc_none);
        add_row("probe_miss", op_wr, reg_cmd, 0, cmd_tlbp, 0, exc_none);
        add_row("miss_idx", op_rd, reg_index, 0, 0, 32'h8000_0005, exc_none);
        add_row("asid5_again", op_wr, reg_entryhi, 0, 32'h0040_0005, 0, exc_none);
        add_row("probe_hit", op_wr, reg_cmd, 0, cmd_tlbp, 0, exc_none);
        add_row("hit_idx", op_rd, reg_index, 0, 0, 32'h0000_0002, exc_none);
        // lo registers still hold entry 5 values here
        add_row("a_tlbr", op_wr, reg_cmd, 0, cmd_tlbr, 0, exc_none);
        add_row("a_hi_rd", op_rd, reg_entryhi, 0, 0, 32'h0040_0005, exc_none);
        add_row("a_lo0_rd", op_rd, reg_entrylo0, 0, 0, 32'h0048_D15E, exc_none);
        add_row("a_lo1_rd", op_rd, reg_entrylo1, 0, 0, 32'h002A_F352, exc_none);
        add_row("b_idx_sel", op_wr, reg_index, 0, 32'h5, 0, exc_none);
        add_row("b_tlbr", op_wr, reg_cmd, 0, cmd_tlbr, 0, exc_none);
        add_row("b_hi_rd", op_rd, reg_entryhi, 0, 0, 32'h1000_0007, exc_none);
        add_row("b_lo0_rd", op_rd, reg_entrylo0, 0, 0, 32'h0001_DDC5, exc_none);
        add_row("b_lo1_rd", op_rd, reg_entrylo1, 0, 0, 32'h0002_2207, exc_none);
    endfunction

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, a response never arrived", cycles);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int          off;
        logic [31:0] va;
        logic [31:0] pa;
        void'($urandom(8));
        arst_n     = 1'b0;
        wb_req     = '0;
        ifetch_req = '0;
        data_req   = '0;
        load_table();
        limit = 10 * rows.size() + 40;
        repeat (16) @(posedge aclk);
        #drive_delay;
        arst_n = 1'b1;
        foreach (rows[i]) begin
            case (rows[i].op)
                op_wr: write_reg(rows[i].name, rows[i].addr[reg_adr_w-1:0], rows[i].wdata);
                op_rd: read_reg(rows[i].name, rows[i].addr[reg_adr_w-1:0], rows[i].exp);
                default: begin
                    off = $urandom % 4096;
                    va  = rows[i].addr | off;
                    pa  = (rows[i].exc == exc_none) ? (rows[i].exp | off) : 32'h0;
                    translate(rows[i].name, rows[i].op == op_data, va, rows[i].store,
                              pa, rows[i].exc);
                end
            endcase
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
src/mmu_pkg.sv
src/tlb_lookup.sv
src/tlb_array.sv
src/xlat_port.sv
src/cp0_mmu_regs.sv
src/mmu_top.sv
+incdir+bench
bench/mmu_tb.sv

/* src/cp0_mmu_regs.sv */
`default_nettype none

module cp0_mmu_regs
    import mmu_pkg::*;
(
    input  wire                          aclk,
    input  wire                          arst_n,
    input  wb_req_t                      wb_req,
    output wb_rsp_t                      wb_rsp,
    input  tlb_entry_t [tlb_entries-1:0] entries,
    output logic [tlb_index_w-1:0]       rd_index,
    input  tlb_entry_t                   rd_entry,
    output tlb_wr_t                      tlb_wr,
    output logic [asid_w-1:0]            cur_asid
);

    logic                   ack;
    logic                   access;
    logic                   wr;
    logic                   do_wi;
    logic                   do_r;
    logic                   do_p;
    logic [31:0]            rd_dat;

    logic                   idx_p;
    logic [tlb_index_w-1:0] idx;
    logic [vpn2_w-1:0]      hi_vpn2;
    logic [asid_w-1:0]      hi_asid;
    tlb_page_t              lo0;
    tlb_page_t              lo1;
    logic                   lo0_g;
    logic                   lo1_g;

    logic                   probe_hit;
    logic [tlb_index_w-1:0] probe_index;

    function automatic logic [31:0] lo_word(tlb_page_t p, logic g);
        return {6'b0, p.pfn, p.c, p.d, p.v, g};
    endfunction

    function automatic tlb_page_t lo_page(logic [31:0] w);
        return '{pfn: w[25:6], c: w[5:3], d: w[2], v: w[1]};
    endfunction

    // single-cycle ack, then a forced gap
    assign access = wb_req.cyc && wb_req.stb && !ack;
    assign wr     = access && wb_req.we;
    assign do_wi  = wr && wb_req.adr == reg_cmd && wb_req.dat == cmd_tlbwi;
    assign do_r   = wr && wb_req.adr == reg_cmd && wb_req.dat == cmd_tlbr;
    assign do_p   = wr && wb_req.adr == reg_cmd && wb_req.dat == cmd_tlbp;

    tlb_lookup probe_i (
        .entries (entries),
        .vpn2    (hi_vpn2),
        .asid    (hi_asid),
        .found   (probe_hit),
        .index   (probe_index),
        .entry   ()
    );

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            ack     <= 1'b0;
            idx_p   <= 1'b0;
            idx     <= '0;
            hi_vpn2 <= '0;
            hi_asid <= '0;
            lo0     <= '0;
            lo1     <= '0;
            lo0_g   <= 1'b0;
            lo1_g   <= 1'b0;
        end else begin
            ack <= access;
            if (wr) begin
                case (wb_req.adr)
                    reg_index: begin
                        idx_p <= wb_req.dat[31];
                        idx   <= wb_req.dat[tlb_index_w-1:0];
                    end
                    reg_entrylo0: begin
                        lo0   <= lo_page(wb_req.dat);
                        lo0_g <= wb_req.dat[0];
                    end
                    reg_entrylo1: begin
                        lo1   <= lo_page(wb_req.dat);
                        lo1_g <= wb_req.dat[0];
                    end
                    reg_entryhi: begin
                        hi_vpn2 <= wb_req.dat[31:13];
                        hi_asid <= wb_req.dat[asid_w-1:0];
                    end
                    default: ;
                endcase
            end
            if (do_r) begin
                hi_vpn2 <= rd_entry.vpn2;
                hi_asid <= rd_entry.asid;
                lo0     <= rd_entry.page0;
                lo1     <= rd_entry.page1;
                lo0_g   <= rd_entry.g;
                lo1_g   <= rd_entry.g;
            end
            // on a miss the old index bits stay
            if (do_p) begin
                idx_p <= !probe_hit;
                if (probe_hit) begin
                    idx <= probe_index;
                end
            end
        end
    end

    always_comb begin
        case (wb_req.adr)
            reg_index:    rd_dat = {idx_p, 27'b0, idx};
            reg_entrylo0: rd_dat = lo_word(lo0, lo0_g);
            reg_entrylo1: rd_dat = lo_word(lo1, lo1_g);
            reg_entryhi:  rd_dat = {hi_vpn2, 5'b0, hi_asid};
            default:      rd_dat = '0;
        endcase
    end

    assign wb_rsp   = '{ack: ack, dat: rd_dat};
    assign rd_index = idx;
    assign cur_asid = hi_asid;
    assign tlb_wr   = '{
        we:    do_wi,
        index: idx,
        entry: '{vpn2: hi_vpn2, asid: hi_asid, g: lo0_g && lo1_g, page0: lo0, page1: lo1}
    };

    ack_single_cycle: assert property (
        @(posedge aclk) disable iff (!arst_n) wb_rsp.ack |=> !wb_rsp.ack
    );

endmodule

`default_nettype wire

/* src/mmu_pkg.sv */
`default_nettype none

package mmu_pkg;

    localparam int tlb_entries = 16;
    localparam int tlb_index_w = 4;
    localparam int vpn2_w      = 19;
    localparam int asid_w      = 8;
    localparam int pfn_w       = 20;
    localparam int reg_adr_w   = 3;

    // wishbone word addresses
    localparam logic [reg_adr_w-1:0] reg_index    = 3'd0;
    localparam logic [reg_adr_w-1:0] reg_entrylo0 = 3'd1;
    localparam logic [reg_adr_w-1:0] reg_entrylo1 = 3'd2;
    localparam logic [reg_adr_w-1:0] reg_entryhi  = 3'd3;
    localparam logic [reg_adr_w-1:0] reg_cmd      = 3'd4;

    // full data word written to reg_cmd
    localparam logic [31:0] cmd_tlbwi = 32'd1;
    localparam logic [31:0] cmd_tlbr  = 32'd2;
    localparam logic [31:0] cmd_tlbp  = 32'd3;

    localparam logic [1:0] exc_none    = 2'd0;
    localparam logic [1:0] exc_refill  = 2'd1;
    localparam logic [1:0] exc_invalid = 2'd2;
    localparam logic [1:0] exc_modify  = 2'd3;

    typedef struct packed {
        logic [pfn_w-1:0] pfn;
        logic [2:0]       c;
        logic             d;
        logic             v;
    } tlb_page_t;

    // even page in page0, odd page in page1
    typedef struct packed {
        logic [vpn2_w-1:0] vpn2;
        logic [asid_w-1:0] asid;
        logic              g;
        tlb_page_t         page0;
        tlb_page_t         page1;
    } tlb_entry_t;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [reg_adr_w-1:0] adr;
        logic [31:0]          dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] vaddr;
        logic        store;
    } xlat_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] paddr;
        logic [1:0]  exc;
    } xlat_rsp_t;

    typedef struct packed {
        logic                   we;
        logic [tlb_index_w-1:0] index;
        tlb_entry_t             entry;
    } tlb_wr_t;

endpackage

`default_nettype wire

/* src/mmu_top.sv */
`default_nettype none

module mmu_top
    import mmu_pkg::*;
(
    input  wire       aclk,
    input  wire       arst_n,
    input  wb_req_t   wb_req,
    output wb_rsp_t   wb_rsp,
    input  xlat_req_t ifetch_req,
    output xlat_rsp_t ifetch_rsp,
    input  xlat_req_t data_req,
    output xlat_rsp_t data_rsp
);

    tlb_entry_t [tlb_entries-1:0] entries;
    tlb_entry_t                   rd_entry;
    logic [tlb_index_w-1:0]       rd_index;
    tlb_wr_t                      tlb_wr;
    logic [asid_w-1:0]            cur_asid;

    cp0_mmu_regs cp0_regs_i (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .entries  (entries),
        .rd_index (rd_index),
        .rd_entry (rd_entry),
        .tlb_wr   (tlb_wr),
        .cur_asid (cur_asid)
    );

    tlb_array tlb_array_i (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .tlb_wr   (tlb_wr),
        .rd_index (rd_index),
        .rd_entry (rd_entry),
        .entries  (entries)
    );

    // fetches never write, so no dirty check
    xlat_port #(
        .check_dirty (1'b0)
    ) ifetch_xlat (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .req      (ifetch_req),
        .rsp      (ifetch_rsp),
        .entries  (entries),
        .cur_asid (cur_asid)
    );

    xlat_port #(
        .check_dirty (1'b1)
    ) data_xlat (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .req      (data_req),
        .rsp      (data_rsp),
        .entries  (entries),
        .cur_asid (cur_asid)
    );

endmodule

`default_nettype wire

/* src/tlb_array.sv */
`default_nettype none

module tlb_array
    import mmu_pkg::*;
(
    input  wire                          aclk,
    input  wire                          arst_n,
    input  tlb_wr_t                      tlb_wr,
    input  wire [tlb_index_w-1:0]        rd_index,
    output tlb_entry_t                   rd_entry,
    output tlb_entry_t [tlb_entries-1:0] entries
);

    // all entries come up invalid so mapped accesses refill
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < tlb_entries; i++) begin
                entries[i] <= '0;
            end
        end else if (tlb_wr.we) begin
            entries[tlb_wr.index] <= tlb_wr.entry;
        end
    end

    assign rd_entry = entries[rd_index];

endmodule

`default_nettype wire

/* src/tlb_lookup.sv */
`default_nettype none

module tlb_lookup
    import mmu_pkg::*;
(
    input  tlb_entry_t [tlb_entries-1:0] entries,
    input  wire [vpn2_w-1:0]             vpn2,
    input  wire [asid_w-1:0]             asid,
    output logic                         found,
    output logic [tlb_index_w-1:0]       index,
    output tlb_entry_t                   entry
);

    logic [tlb_entries-1:0] hit;

    always_comb begin
        for (int i = 0; i < tlb_entries; i++) begin
            hit[i] = (entries[i].vpn2 == vpn2) &&
                     (entries[i].g || entries[i].asid == asid);
        end
    end

    // scan downwards so the lowest match is the one left standing
    always_comb begin
        found = 1'b0;
        index = '0;
        for (int i = tlb_entries - 1; i >= 0; i--) begin
            if (hit[i]) begin
                found = 1'b1;
                index = tlb_index_w'(i);
            end
        end
    end

    assign entry = entries[index];

endmodule

`default_nettype wire

/* src/xlat_port.sv */
`default_nettype none

module xlat_port
    import mmu_pkg::*;
#(
    parameter bit check_dirty = 1'b0
) (
    input  wire                          aclk,
    input  wire                          arst_n,
    input  xlat_req_t                    req,
    output xlat_rsp_t                    rsp,
    input  tlb_entry_t [tlb_entries-1:0] entries,
    input  wire [asid_w-1:0]             cur_asid
);

    logic                   hit;
    tlb_entry_t             hit_entry;
    tlb_page_t              page;
    logic                   unmapped;
    logic [31:0]            paddr_d;
    logic [1:0]             exc_d;

    logic                   rsp_valid;
    logic [31:0]            rsp_paddr;
    logic [1:0]             rsp_exc;

    tlb_lookup lookup_i (
        .entries (entries),
        .vpn2    (req.vaddr[31:13]),
        .asid    (cur_asid),
        .found   (hit),
        .index   (),
        .entry   (hit_entry)
    );

    // kseg0 and kseg1 bypass the TLB
    assign unmapped = req.vaddr[31:30] == 2'b10;
    assign page     = req.vaddr[12] ? hit_entry.page1 : hit_entry.page0;

    always_comb begin
        exc_d   = exc_none;
        paddr_d = {page.pfn, req.vaddr[11:0]};
        if (unmapped) begin
            paddr_d = {3'b000, req.vaddr[28:0]};
        end else if (!hit) begin
            exc_d = exc_refill;
        end else if (!page.v) begin
            exc_d = exc_invalid;
        end else if (check_dirty && req.store && !page.d) begin
            exc_d = exc_modify;
        end
        if (exc_d != exc_none) begin
            paddr_d = '0;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req.valid;
        end
    end

    always_ff @(posedge aclk) begin
        rsp_paddr <= paddr_d;
        rsp_exc   <= exc_d;
    end

    assign rsp = '{valid: rsp_valid, paddr: rsp_paddr, exc: rsp_exc};

    rsp_follows_req: assert property (
        @(posedge aclk) disable iff (!arst_n) rsp.valid |-> $past(req.valid)
    );

endmodule

`default_nettype wire
